// File: Bender.yml
package:
  name: radio_fe

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/radio_fe_pkg.sv
      - rtl/radio_input_capture.sv
      - rtl/radio_fe_channel.sv
      - rtl/radio_output_map.sv
      - rtl/radio_fe_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/radio_fe_tb.sv

// File: dv/radio_fe_tb.sv
// Testbench with clock, reset, random stimulus, reference model and checking assertions
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_defines.svh"

module radio_fe_tb import radio_fe_pkg::*;;

   localparam logic [7:0] CH1_SEL     = 8'd1 << `RF_CH_SEL_BIT;
   localparam logic [7:0] CH0_CTRL    = `SR_CH_BASE | `SR_CH_CTRL;
   localparam logic [7:0] CH0_LEDS    = `SR_CH_BASE | `SR_CH_LEDS;
   localparam logic [7:0] CH1_CTRL    = CH0_CTRL | CH1_SEL;
   localparam logic [7:0] CH1_LEDS    = CH0_LEDS | CH1_SEL;
   localparam logic [7:0] RB_CH1_CTRL = `RB_CH_CTRL | CH1_SEL;
   localparam logic [7:0] RB_CH1_LEDS = `RB_CH_LEDS | CH1_SEL;
   localparam logic [7:0] MAPPED_RB [7] = '{`RB_MISC_IN, `RB_GPIO_IN, `RB_MISC_OUT,
      `RB_CH_CTRL, `RB_CH_LEDS, RB_CH1_CTRL, RB_CH1_LEDS};
   localparam logic [7:0] UNMAPPED_RB [5] = '{8'd3, 8'd8, 8'd18, 8'd26, 8'd255};

   logic                  radio_clk;
   logic                  i_rst_n;
   iq_sample_t            i_rx;
   logic                  i_rx_stb;
   iq_sample_t            i_tx;
   logic                  i_tx_stb;
   logic [`RF_DATA_W-1:0] i_misc_in;
   logic [`RF_DATA_W-1:0] i_gpio_in;
   set_bus_t              i_set;
   rb_req_t               i_rb;
   iq_sample_t            o_rx0;
   iq_sample_t            o_rx1;
   logic                  o_rx_stb;
   iq_sample_t            o_tx;
   logic [`RF_DATA_W-1:0] o_gpio_out;
   logic [`RF_DATA_W-1:0] o_gpio_ddr;
   logic [`RF_DATA_W-1:0] o_misc_out;
   logic [`RF_LED_W-1:0]  o_radio_led;
   rb_resp_t              o_rb;
   logic                  rst_prev = 1'b0;

   radio_fe_top radio_fe_top_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_rx(i_rx), .i_rx_stb(i_rx_stb), .i_tx(i_tx), .i_tx_stb(i_tx_stb),
      .i_misc_in(i_misc_in), .i_gpio_in(i_gpio_in), .i_set(i_set), .i_rb(i_rb),
      .o_rx0(o_rx0), .o_rx1(o_rx1), .o_rx_stb(o_rx_stb), .o_tx(o_tx),
      .o_gpio_out(o_gpio_out), .o_gpio_ddr(o_gpio_ddr), .o_misc_out(o_misc_out),
      .o_radio_led(o_radio_led), .o_rb(o_rb)
   );

   initial begin
      radio_clk = 1'b0;
      forever #10 radio_clk = ~radio_clk;
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   set_bus_t              set_d1;
   rb_req_t               rb_d1;
   iq_sample_t            rx_d1;
   logic                  rx_stb_d1;
   logic [`RF_DATA_W-1:0] misc_in_d1;
   logic [`RF_DATA_W-1:0] gpio_in_d1;
   fe_ctrl_t              m_ctrl0 = '0;
   fe_ctrl_t              m_ctrl1 = '0;
   logic [`RF_LED_W-1:0]  m_leds0 = '0;
   logic [`RF_LED_W-1:0]  m_leds1 = '0;
   logic [`RF_DATA_W-1:0] m_misc_out = '0;
   logic [`RF_DATA_W-1:0] m_gpio_out = '0;
   logic [`RF_DATA_W-1:0] m_gpio_ddr = '0;
   iq_sample_t            exp_rx0;
   iq_sample_t            exp_rx1;
   logic                  exp_rx_stb = 1'b0;
   iq_sample_t            exp_tx = '0;
   logic [`RF_DATA_W-1:0] exp_misc_out = '0;
   rb_resp_t              exp_rb = '0;

   // Swap I and Q, then negate Q
   function automatic iq_sample_t expected_iq(input iq_sample_t s, input fe_ctrl_t c);
      logic [15:0] ei;
      logic [15:0] eq;
      ei = c.swap_iq ? s.q : s.i;
      eq = c.swap_iq ? s.i : s.q;
      if (c.invert_q) begin
         eq = 16'd0 - eq;
      end
      return {ei, eq};
   endfunction

   function automatic rb_resp_t expected_read(input rb_req_t req);
      rb_resp_t e;
      e = '0;
      if (req.stb) begin
         e.valid = 1'b1;
         case (req.addr)
            `RB_MISC_IN:  e.data = misc_in_d1;
            `RB_GPIO_IN:  e.data = gpio_in_d1;
            `RB_MISC_OUT: e.data = m_misc_out;
            `RB_CH_CTRL:  e.data = {30'd0, m_ctrl0};
            `RB_CH_LEDS:  e.data = {29'd0, m_leds0};
            RB_CH1_CTRL:  e.data = {30'd0, m_ctrl1};
            RB_CH1_LEDS:  e.data = {29'd0, m_leds1};
            default:      e.valid = 1'b0;
         endcase
      end
      return e;
   endfunction

   always @(posedge radio_clk) begin
      rst_prev <= !i_rst_n;
      if (!i_rst_n) begin
         set_d1 <= '0;
         rb_d1 <= '0;
         rx_stb_d1 <= 1'b0;
         misc_in_d1 <= '0;
         gpio_in_d1 <= '0;
         m_ctrl0 <= '0;
         m_ctrl1 <= '0;
         m_leds0 <= '0;
         m_leds1 <= '0;
         m_misc_out <= '0;
         m_gpio_out <= '0;
         m_gpio_ddr <= '0;
         exp_rx_stb <= 1'b0;
         exp_tx <= '0;
         exp_misc_out <= '0;
         exp_rb <= '0;
      end else begin
         set_d1 <= i_set;
         rb_d1 <= i_rb;
         rx_d1 <= i_rx;
         rx_stb_d1 <= i_rx_stb;
         misc_in_d1 <= i_misc_in;
         gpio_in_d1 <= i_gpio_in;
         if (set_d1.stb) begin
            case (set_d1.addr)
               `SR_MISC_OUT: m_misc_out <= set_d1.data;
               `SR_GPIO_OUT: m_gpio_out <= set_d1.data;
               `SR_GPIO_DDR: m_gpio_ddr <= set_d1.data;
               CH0_CTRL:     m_ctrl0 <= fe_ctrl_t'(set_d1.data[1:0]);
               CH0_LEDS:     m_leds0 <= set_d1.data[`RF_LED_W-1:0];
               CH1_CTRL:     m_ctrl1 <= fe_ctrl_t'(set_d1.data[1:0]);
               CH1_LEDS:     m_leds1 <= set_d1.data[`RF_LED_W-1:0];
               default: ;
            endcase
         end
         // RX lags two cycles and TX one
         exp_rx_stb <= rx_stb_d1;
         if (rx_stb_d1) begin
            exp_rx0 <= expected_iq(rx_d1, m_ctrl0);
            exp_rx1 <= expected_iq(rx_d1, m_ctrl1);
         end
         exp_tx <= i_tx_stb ? expected_iq(i_tx, m_ctrl0) : '0;
         exp_misc_out <= m_misc_out;
         exp_rb <= expected_read(rb_d1);
      end
   end

   //////////////////////////////////////////////////
   // Failure reporting and checks
   //////////////////////////////////////////////////

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "run stopped after the first error");
   endtask

   task automatic mismatch_error(input string sig, input logic [63:0] exp,
                                 input logic [63:0] act);
      $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, sig, exp, act);
      abort_run();
   endtask

   task automatic timeout_error(input string what);
      $display("Timeout at %0t: %s", $time, what);
      abort_run();
   endtask

   // One cycle into reset every output is idle
   a_reset_stb : assert property (@(posedge radio_clk)
      rst_prev |-> ({o_rx_stb, o_rb.valid} == 2'b00))
      else mismatch_error("o_rx_stb,o_rb.valid", 0, $sampled({o_rx_stb, o_rb.valid}));
   a_reset_gpio : assert property (@(posedge radio_clk)
      rst_prev |-> ({o_gpio_out, o_gpio_ddr} == '0))
      else mismatch_error("o_gpio_out,o_gpio_ddr", 0, $sampled({o_gpio_out, o_gpio_ddr}));
   a_reset_misc : assert property (@(posedge radio_clk)
      rst_prev |-> ({o_misc_out, o_radio_led} == '0))
      else mismatch_error("o_misc_out,o_radio_led", 0, $sampled({o_misc_out, o_radio_led}));

   a_rx_stb : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rx_stb == exp_rx_stb)
      else mismatch_error("o_rx_stb", $sampled(exp_rx_stb), $sampled(o_rx_stb));
   a_rx0 : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rx_stb |-> o_rx0 == exp_rx0)
      else mismatch_error("o_rx0", $sampled(exp_rx0), $sampled(o_rx0));
   a_rx1 : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rx_stb |-> o_rx1 == exp_rx1)
      else mismatch_error("o_rx1", $sampled(exp_rx1), $sampled(o_rx1));
   a_tx : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_tx == exp_tx)
      else mismatch_error("o_tx", $sampled(exp_tx), $sampled(o_tx));
   a_leds : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_radio_led == (m_leds0 | m_leds1))
      else mismatch_error("o_radio_led", $sampled(m_leds0 | m_leds1), $sampled(o_radio_led));
   a_gpio_out : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_gpio_out == m_gpio_out)
      else mismatch_error("o_gpio_out", $sampled(m_gpio_out), $sampled(o_gpio_out));
   a_gpio_ddr : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_gpio_ddr == m_gpio_ddr)
      else mismatch_error("o_gpio_ddr", $sampled(m_gpio_ddr), $sampled(o_gpio_ddr));
   a_misc_out : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_misc_out == exp_misc_out)
      else mismatch_error("o_misc_out", $sampled(exp_misc_out), $sampled(o_misc_out));
   a_rb_valid : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rb.valid == exp_rb.valid)
      else mismatch_error("o_rb.valid", $sampled(exp_rb.valid), $sampled(o_rb.valid));
   a_rb_data : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rb.valid |-> o_rb.data == exp_rb.data)
      else mismatch_error("o_rb.data", $sampled(exp_rb.data), $sampled(o_rb.data));

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   // Random ADC, DAC and pin traffic on every falling edge
   task automatic drive_stream();
      forever begin
         @(negedge radio_clk);
         i_rx = iq_sample_t'($urandom);
         i_rx_stb = ($urandom_range(0, 7) != 0);
         i_tx = iq_sample_t'($urandom);
         i_tx_stb = ($urandom_range(0, 3) != 0);
         i_misc_in = $urandom;
         i_gpio_in = $urandom;
      end
   endtask

   // Bus tasks start and end on a falling edge
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      i_set = '{stb: 1'b1, addr: addr, data: data};
      @(negedge radio_clk);
      i_set.stb = 1'b0;
   endtask

   task automatic read_mapped(input logic [7:0] addr);
      int cycles;
      i_rb = '{stb: 1'b1, addr: addr};
      @(negedge radio_clk);
      i_rb.stb = 1'b0;
      cycles = 0;
      while (!o_rb.valid && cycles < 6) begin
         @(negedge radio_clk);
         cycles++;
      end
      if (!o_rb.valid) begin
         timeout_error($sformatf("no readback response for address %0d", addr));
      end
   endtask

   task automatic read_unmapped(input logic [7:0] addr);
      i_rb = '{stb: 1'b1, addr: addr};
      @(negedge radio_clk);
      i_rb.stb = 1'b0;
      repeat (4) @(negedge radio_clk);
   endtask

   task automatic wait_rx_start();
      int cycles;
      cycles = 0;
      while (!o_rx_stb && cycles < 8) begin
         @(negedge radio_clk);
         cycles++;
      end
      if (!o_rx_stb) begin
         timeout_error("receive strobe never appeared on o_rx_stb");
      end
   endtask

   // Watchdog over the whole run
   initial begin
      for (int c = 0; c < 2000; c++) begin
         @(posedge radio_clk);
      end
      timeout_error("run did not finish within 2000 clock cycles");
   end

   initial begin
      void'($urandom(32'h33af7699));
      i_rst_n = 1'b0;
      i_rx = '0;
      i_rx_stb = 1'b0;
      i_tx = '0;
      i_tx_stb = 1'b0;
      i_misc_in = '0;
      i_gpio_in = '0;
      i_set = '0;
      i_rb = '0;
      repeat (16) @(posedge radio_clk);
      @(negedge radio_clk);
      i_rst_n = 1'b1;
      fork
         drive_stream();
      join_none
      wait_rx_start();
      // All four corrections with different settings on the two channels
      for (int combo = 0; combo < 4; combo++) begin
         write_reg(CH0_CTRL, combo);
         write_reg(CH1_CTRL, 3 - combo);
         repeat (24) @(negedge radio_clk);
      end
      for (int n = 0; n < 12; n++) begin
         write_reg(CH0_LEDS, $urandom);
         write_reg(CH1_LEDS, $urandom);
         write_reg(`SR_MISC_OUT, $urandom);
         write_reg(`SR_GPIO_OUT, $urandom);
         write_reg(`SR_GPIO_DDR, $urandom);
         repeat ($urandom_range(0, 3)) @(negedge radio_clk);
      end
      write_reg(CH0_CTRL, $urandom);
      write_reg(CH1_CTRL, $urandom);
      foreach (MAPPED_RB[k]) begin
         read_mapped(MAPPED_RB[k]);
      end
      foreach (UNMAPPED_RB[k]) begin
         read_unmapped(UNMAPPED_RB[k]);
      end
      repeat (4) @(negedge radio_clk);
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/radio_fe_pkg.sv
rtl/radio_input_capture.sv
rtl/radio_fe_channel.sv
rtl/radio_output_map.sv
rtl/radio_fe_top.sv
dv/radio_fe_tb.sv

// File: rtl/radio_fe_channel.sv
// One front end channel with control and LED registers, RX correction and optional TX correction
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_defines.svh"

module radio_fe_channel import radio_fe_pkg::*; #(
   parameter bit WITH_TX = 1'b1
) (
   input  wire                      radio_clk,
   input  wire                      i_rst_n,
   // Sample from stage 1
   input  wire iq_sample_t          i_sample,
   input  wire                      i_sample_stb,
   // Register buses, already qualified for this channel
   input  wire set_bus_t            i_set,
   input  wire rb_req_t             i_rb,
   // Transmit word towards the DAC
   input  wire iq_sample_t          i_tx,
   input  wire                      i_tx_stb,
   output iq_sample_t               o_sample,
   output logic                     o_sample_stb,
   output iq_sample_t               o_tx,
   output logic [`RF_LED_W-1:0]     o_leds,
   output rb_resp_t                 o_rb
);

   fe_ctrl_t                  ctrl_r;
   logic [`RF_LED_W-1:0]      leds_r;
   logic [`RF_CH_OFF_W-1:0]   set_off;
   logic [`RF_ADDR_W-1:0]     rb_addr;
   logic [`RF_DATA_W-1:0]     rb_mux;
   iq_sample_t                sample_r;
   logic                      sample_stb_r;
   logic                      rb_valid_r;
   logic [`RF_DATA_W-1:0]     rb_data_r;

   //////////////////////////////////////////////////
   // I/Q correction
   //////////////////////////////////////////////////

   // Swap first, then negate whatever ends up in Q
   function automatic iq_sample_t fe_correct(input iq_sample_t s, input fe_ctrl_t c);
      iq_sample_t r;
      r = s;
      if (c.swap_iq) begin
         r.i = s.q;
         r.q = s.i;
      end
      if (c.invert_q) begin
         // Full scale negative wraps back onto itself
         r.q = ~r.q + 1'b1;
      end
      return r;
   endfunction

   //////////////////////////////////////////////////
   // Settings registers
   //////////////////////////////////////////////////

   assign set_off = i_set.addr[`RF_CH_OFF_W-1:0];

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         ctrl_r <= '0;
         leds_r <= '0;
      end else if (i_set.stb) begin
         case (set_off)
            `SR_CH_CTRL: ctrl_r <= fe_ctrl_t'(i_set.data[$bits(fe_ctrl_t)-1:0]);
            `SR_CH_LEDS: leds_r <= i_set.data[`RF_LED_W-1:0];
            default: ;
         endcase
      end
   end

   assign o_leds = leds_r;

   // Receive path, one register stage
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         sample_stb_r <= 1'b0;
      end else begin
         sample_stb_r <= i_sample_stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_sample_stb) begin
         sample_r <= fe_correct(i_sample, ctrl_r);
      end
   end

   assign o_sample     = sample_r;
   assign o_sample_stb = sample_stb_r;

   // Transmit path shares the control register
   generate
      if (WITH_TX) begin : g_tx
         iq_sample_t tx_r;

         always_ff @(posedge radio_clk) begin
            if (!i_rst_n) begin
               tx_r <= '0;
            end else begin
               // Idle DAC gets zeros
               tx_r <= i_tx_stb ? fe_correct(i_tx, ctrl_r) : '0;
            end
         end

         assign o_tx = tx_r;
      end else begin : g_no_tx
         assign o_tx = '0;
      end
   endgenerate

   //////////////////////////////////////////////////
   // Readback
   //////////////////////////////////////////////////

   // Fold both channels onto the channel 0 addresses
   always_comb begin
      rb_addr = i_rb.addr;
      rb_addr[`RF_CH_SEL_BIT] = 1'b0;
   end

   always_comb begin
      rb_mux = '0;
      case (rb_addr)
         `RB_CH_CTRL: rb_mux[$bits(fe_ctrl_t)-1:0] = ctrl_r;
         `RB_CH_LEDS: rb_mux[`RF_LED_W-1:0] = leds_r;
         default: rb_mux = '0;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         rb_valid_r <= 1'b0;
      end else begin
         rb_valid_r <= i_rb.stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      rb_data_r <= rb_mux;
   end

   assign o_rb = '{valid: rb_valid_r, data: rb_data_r};

   // Stage 1 only passes on reads of this channel's registers
   a_rb_mapped : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      i_rb.stb |-> (rb_addr == `RB_CH_CTRL || rb_addr == `RB_CH_LEDS))
      else $error("channel readback strobe for an unmapped address");

endmodule

`default_nettype wire

// File: rtl/radio_fe_defines.svh
// Bus widths, field widths and the register and readback address map
`ifndef RADIO_FE_DEFINES_SVH
`define RADIO_FE_DEFINES_SVH

// Bus and sample widths
`define RF_SAMPLE_W   32
`define RF_ADDR_W     8
`define RF_DATA_W     32
`define RF_LED_W      3

//////////////////////////////////////////////////
// Settings bus addresses
//////////////////////////////////////////////////

// Daughterboard registers live below 16
`define SR_MISC_OUT   8'd0
`define SR_GPIO_OUT   8'd1
`define SR_GPIO_DDR   8'd2

// Channel block starts at 16 and bit 3 picks the channel
`define SR_CH_BASE    8'd16
`define RF_CH_SEL_BIT 3
`define RF_CH_OFF_W   3
`define SR_CH_CTRL    3'd0
`define SR_CH_LEDS    3'd1

// Readback addresses, channel ones repeat at +8 for channel 1
`define RB_MISC_IN    8'd0
`define RB_GPIO_IN    8'd1
`define RB_MISC_OUT   8'd2
`define RB_CH_CTRL    8'd16
`define RB_CH_LEDS    8'd17

`endif

// File: rtl/radio_fe_pkg.sv
// Packed structs for samples, settings and readback buses, control fields and target enum
`default_nettype none

`include "radio_fe_defines.svh"

package radio_fe_pkg;

   // One ADC or DAC word, I in the upper half
   typedef struct packed {
      logic [`RF_SAMPLE_W/2-1:0] i;
      logic [`RF_SAMPLE_W/2-1:0] q;
   } iq_sample_t;

   //////////////////////////////////////////////////
   // Register buses
   //////////////////////////////////////////////////

   // Settings write, valid only in the strobe cycle
   typedef struct packed {
      logic                  stb;
      logic [`RF_ADDR_W-1:0] addr;
      logic [`RF_DATA_W-1:0] data;
   } set_bus_t;

   typedef struct packed {
      logic                  stb;
      logic [`RF_ADDR_W-1:0] addr;
   } rb_req_t;

   typedef struct packed {
      logic                  valid;
      logic [`RF_DATA_W-1:0] data;
   } rb_resp_t;

   // Front end correction, swap_iq is bit 1 and invert_q bit 0
   typedef struct packed {
      logic swap_iq;
      logic invert_q;
   } fe_ctrl_t;

   // Where a bus access lands
   typedef enum logic [1:0] {
      TGT_NONE,
      TGT_DB,
      TGT_CH0,
      TGT_CH1
   } target_e;

endpackage

`default_nettype wire

// File: rtl/radio_fe_top.sv
// Top level joining input capture, two front end channels and the output map
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_defines.svh"

module radio_fe_top import radio_fe_pkg::*; (
   input  wire                      radio_clk,
   input  wire                      i_rst_n,
   // ADC and DAC words
   input  wire iq_sample_t          i_rx,
   input  wire                      i_rx_stb,
   input  wire iq_sample_t          i_tx,
   input  wire                      i_tx_stb,
   // Daughterboard pins
   input  wire [`RF_DATA_W-1:0]     i_misc_in,
   input  wire [`RF_DATA_W-1:0]     i_gpio_in,
   // Register buses
   input  wire set_bus_t            i_set,
   input  wire rb_req_t             i_rb,
   output iq_sample_t               o_rx0,
   output iq_sample_t               o_rx1,
   output logic                     o_rx_stb,
   output iq_sample_t               o_tx,
   output logic [`RF_DATA_W-1:0]    o_gpio_out,
   output logic [`RF_DATA_W-1:0]    o_gpio_ddr,
   output logic [`RF_DATA_W-1:0]    o_misc_out,
   output logic [`RF_LED_W-1:0]     o_radio_led,
   output rb_resp_t                 o_rb
);

   iq_sample_t            s1_sample;
   logic                  s1_stb;
   set_bus_t              s1_set_ch0;
   set_bus_t              s1_set_ch1;
   set_bus_t              s1_db_set;
   rb_req_t               s1_rb_ch0;
   rb_req_t               s1_rb_ch1;
   rb_req_t               s1_db_rb;
   logic [`RF_DATA_W-1:0] s1_misc_in;
   logic [`RF_DATA_W-1:0] s1_gpio_in;
   iq_sample_t            ch0_sample;
   iq_sample_t            ch1_sample;
   logic                  ch0_stb;
   logic [`RF_LED_W-1:0]  ch0_leds;
   logic [`RF_LED_W-1:0]  ch1_leds;
   rb_resp_t              ch0_rb;
   rb_resp_t              ch1_rb;

   radio_input_capture radio_input_capture_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_rx(i_rx), .i_rx_stb(i_rx_stb), .i_set(i_set), .i_rb(i_rb),
      .i_misc_in(i_misc_in), .i_gpio_in(i_gpio_in),
      .o_sample(s1_sample), .o_sample_stb(s1_stb),
      .o_set_ch0(s1_set_ch0), .o_set_ch1(s1_set_ch1), .o_set_db(s1_db_set),
      .o_rb_ch0(s1_rb_ch0), .o_rb_ch1(s1_rb_ch1), .o_rb_db(s1_db_rb),
      .o_misc_in(s1_misc_in), .o_gpio_in(s1_gpio_in)
   );

   // Both channels see the same ADC word, only channel 0 drives the DAC
   radio_fe_channel #(.WITH_TX(1'b1)) radio_fe_channel_0_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_sample(s1_sample), .i_sample_stb(s1_stb),
      .i_set(s1_set_ch0), .i_rb(s1_rb_ch0),
      .i_tx(i_tx), .i_tx_stb(i_tx_stb),
      .o_sample(ch0_sample), .o_sample_stb(ch0_stb), .o_tx(o_tx),
      .o_leds(ch0_leds), .o_rb(ch0_rb)
   );

   radio_fe_channel #(.WITH_TX(1'b0)) radio_fe_channel_1_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_sample(s1_sample), .i_sample_stb(s1_stb),
      .i_set(s1_set_ch1), .i_rb(s1_rb_ch1),
      .i_tx('0), .i_tx_stb(1'b0),
      .o_sample(ch1_sample), .o_sample_stb(), .o_tx(),
      .o_leds(ch1_leds), .o_rb(ch1_rb)
   );

   radio_output_map radio_output_map_inst (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set_db(s1_db_set), .i_rb_db(s1_db_rb),
      .i_misc_in(s1_misc_in), .i_gpio_in(s1_gpio_in),
      .i_leds0(ch0_leds), .i_leds1(ch1_leds),
      .i_rb_ch0(ch0_rb), .i_rb_ch1(ch1_rb),
      .o_gpio_out(o_gpio_out), .o_gpio_ddr(o_gpio_ddr), .o_misc_out(o_misc_out),
      .o_radio_led(o_radio_led), .o_rb(o_rb)
   );

   assign o_rx0    = ch0_sample;
   assign o_rx1    = ch1_sample;
   assign o_rx_stb = ch0_stb;

endmodule

`default_nettype wire

// File: rtl/radio_input_capture.sv
// Stage 1 input registers with settings and readback address decode
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_defines.svh"

module radio_input_capture import radio_fe_pkg::*; (
   input  wire                      radio_clk,
   input  wire                      i_rst_n,
   input  wire iq_sample_t          i_rx,
   input  wire                      i_rx_stb,
   input  wire set_bus_t            i_set,
   input  wire rb_req_t             i_rb,
   input  wire [`RF_DATA_W-1:0]     i_misc_in,
   input  wire [`RF_DATA_W-1:0]     i_gpio_in,
   output iq_sample_t               o_sample,
   output logic                     o_sample_stb,
   output set_bus_t                 o_set_ch0,
   output set_bus_t                 o_set_ch1,
   output set_bus_t                 o_set_db,
   output rb_req_t                  o_rb_ch0,
   output rb_req_t                  o_rb_ch1,
   output rb_req_t                  o_rb_db,
   output logic [`RF_DATA_W-1:0]    o_misc_in,
   output logic [`RF_DATA_W-1:0]    o_gpio_in
);

   iq_sample_t            sample_r;
   logic                  sample_stb_r;
   logic [`RF_ADDR_W-1:0] set_addr_r;
   logic [`RF_DATA_W-1:0] set_data_r;
   logic [`RF_ADDR_W-1:0] rb_addr_r;
   target_e               set_tgt_r;
   target_e               rb_tgt_r;
   logic [`RF_DATA_W-1:0] misc_in_r;
   logic [`RF_DATA_W-1:0] gpio_in_r;

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////

   // Write map with only the listed offsets mapped
   function automatic target_e set_target(input logic [`RF_ADDR_W-1:0] addr);
      logic [`RF_ADDR_W-1:0] ch_addr;
      target_e               tgt;
      ch_addr = addr;
      ch_addr[`RF_CH_SEL_BIT] = 1'b0;
      tgt = TGT_NONE;
      if (addr == `SR_MISC_OUT || addr == `SR_GPIO_OUT || addr == `SR_GPIO_DDR) begin
         tgt = TGT_DB;
      end else if (ch_addr == (`SR_CH_BASE | `SR_CH_CTRL) ||
                   ch_addr == (`SR_CH_BASE | `SR_CH_LEDS)) begin
         tgt = addr[`RF_CH_SEL_BIT] ? TGT_CH1 : TGT_CH0;
      end
      return tgt;
   endfunction

   function automatic target_e rb_target(input logic [`RF_ADDR_W-1:0] addr);
      logic [`RF_ADDR_W-1:0] ch_addr;
      target_e               tgt;
      ch_addr = addr;
      ch_addr[`RF_CH_SEL_BIT] = 1'b0;
      tgt = TGT_NONE;
      if (addr == `RB_MISC_IN || addr == `RB_GPIO_IN || addr == `RB_MISC_OUT) begin
         tgt = TGT_DB;
      end else if (ch_addr == `RB_CH_CTRL || ch_addr == `RB_CH_LEDS) begin
         tgt = addr[`RF_CH_SEL_BIT] ? TGT_CH1 : TGT_CH0;
      end
      return tgt;
   endfunction

   // Strobes and captured inputs
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         sample_stb_r <= 1'b0;
         set_tgt_r    <= TGT_NONE;
         rb_tgt_r     <= TGT_NONE;
         misc_in_r    <= '0;
         gpio_in_r    <= '0;
      end else begin
         sample_stb_r <= i_rx_stb;
         set_tgt_r    <= i_set.stb ? set_target(i_set.addr) : TGT_NONE;
         rb_tgt_r     <= i_rb.stb ? rb_target(i_rb.addr) : TGT_NONE;
         misc_in_r    <= i_misc_in;
         gpio_in_r    <= i_gpio_in;
      end
   end

   // Payload
   always_ff @(posedge radio_clk) begin
      if (i_rx_stb) begin
         sample_r <= i_rx;
      end
      set_addr_r <= i_set.addr;
      set_data_r <= i_set.data;
      rb_addr_r  <= i_rb.addr;
   end

   assign o_sample     = sample_r;
   assign o_sample_stb = sample_stb_r;
   assign o_misc_in    = misc_in_r;
   assign o_gpio_in    = gpio_in_r;

   // Only the decoded target sees its strobe
   assign o_set_ch0 = '{stb: (set_tgt_r == TGT_CH0), addr: set_addr_r, data: set_data_r};
   assign o_set_ch1 = '{stb: (set_tgt_r == TGT_CH1), addr: set_addr_r, data: set_data_r};
   assign o_set_db  = '{stb: (set_tgt_r == TGT_DB), addr: set_addr_r, data: set_data_r};
   assign o_rb_ch0  = '{stb: (rb_tgt_r == TGT_CH0), addr: rb_addr_r};
   assign o_rb_ch1  = '{stb: (rb_tgt_r == TGT_CH1), addr: rb_addr_r};
   assign o_rb_db   = '{stb: (rb_tgt_r == TGT_DB), addr: rb_addr_r};

   // Strobed writes land where the address bits point
   a_set_decode : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      (!o_set_db.stb || set_addr_r < `SR_CH_BASE) &&
      (!o_set_ch0.stb || ((set_addr_r & `SR_CH_BASE) != 0 && !set_addr_r[`RF_CH_SEL_BIT])) &&
      (!o_set_ch1.stb || ((set_addr_r & `SR_CH_BASE) != 0 && set_addr_r[`RF_CH_SEL_BIT])))
      else $error("settings write decoded to the wrong target");

endmodule

`default_nettype wire

// File: rtl/radio_output_map.sv
// Stage 3 daughterboard registers, LED overlay, misc-out register and readback merge
`timescale 1ns/1ns
`default_nettype none

`include "radio_fe_defines.svh"

module radio_output_map import radio_fe_pkg::*; (
   input  wire                      radio_clk,
   input  wire                      i_rst_n,
   input  wire set_bus_t            i_set_db,
   input  wire rb_req_t             i_rb_db,
   input  wire [`RF_DATA_W-1:0]     i_misc_in,
   input  wire [`RF_DATA_W-1:0]     i_gpio_in,
   input  wire [`RF_LED_W-1:0]      i_leds0,
   input  wire [`RF_LED_W-1:0]      i_leds1,
   input  wire rb_resp_t            i_rb_ch0,
   input  wire rb_resp_t            i_rb_ch1,
   output logic [`RF_DATA_W-1:0]    o_gpio_out,
   output logic [`RF_DATA_W-1:0]    o_gpio_ddr,
   output logic [`RF_DATA_W-1:0]    o_misc_out,
   output logic [`RF_LED_W-1:0]     o_radio_led,
   output rb_resp_t                 o_rb
);

   logic [`RF_DATA_W-1:0] misc_out_r;
   logic [`RF_DATA_W-1:0] misc_out_q;
   logic [`RF_DATA_W-1:0] gpio_out_r;
   logic [`RF_DATA_W-1:0] gpio_ddr_r;
   logic                  db_rb_valid_r;
   logic [`RF_DATA_W-1:0] db_rb_data_r;

   // Daughterboard registers
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         misc_out_r <= '0;
         gpio_out_r <= '0;
         gpio_ddr_r <= '0;
         misc_out_q <= '0;
      end else begin
         if (i_set_db.stb) begin
            case (i_set_db.addr)
               `SR_MISC_OUT: misc_out_r <= i_set_db.data;
               `SR_GPIO_OUT: gpio_out_r <= i_set_db.data;
               `SR_GPIO_DDR: gpio_ddr_r <= i_set_db.data;
               default: ;
            endcase
         end
         // extra flop before the misc pins leave the block
         misc_out_q <= misc_out_r;
      end
   end

   assign o_gpio_out = gpio_out_r;
   assign o_gpio_ddr = gpio_ddr_r;
   assign o_misc_out = misc_out_q;

   // Both channels light the same LEDs
   assign o_radio_led = i_leds0 | i_leds1;

   //////////////////////////////////////////////////
   // Readback
   //////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         db_rb_valid_r <= 1'b0;
      end else begin
         db_rb_valid_r <= i_rb_db.stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      case (i_rb_db.addr)
         `RB_MISC_IN:  db_rb_data_r <= i_misc_in;
         `RB_GPIO_IN:  db_rb_data_r <= i_gpio_in;
         `RB_MISC_OUT: db_rb_data_r <= misc_out_r;
         default:      db_rb_data_r <= '0;
      endcase
   end

   // At most one source answers, so an OR of gated data is enough
   assign o_rb.valid = db_rb_valid_r | i_rb_ch0.valid | i_rb_ch1.valid;
   assign o_rb.data  = ({`RF_DATA_W{db_rb_valid_r}} & db_rb_data_r)
                     | ({`RF_DATA_W{i_rb_ch0.valid}} & i_rb_ch0.data)
                     | ({`RF_DATA_W{i_rb_ch1.valid}} & i_rb_ch1.data);

   a_rb_no_collision : assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $onehot0({db_rb_valid_r, i_rb_ch0.valid, i_rb_ch1.valid}))
      else $error("two readback responses valid in the same cycle");

endmodule

`default_nettype wire
